// ==== scsi_dma_pkg.sv ====
package scsi_dma_pkg;

    // datapath widths
    localparam int WORD_W  = 32;
    localparam int BYTE_W  = 8;
    localparam int LANES   = WORD_W / BYTE_W;
    // byte counter width
    localparam int COUNT_W = 16;

    // transfer mode, written through reg_ctrl
    typedef enum logic [2:0] {
        mode_idle    = 3'd0,
        mode_dma_out = 3'd1,
        mode_dma_in  = 3'd2,
        mode_pio_out = 3'd3,
        mode_pio_in  = 3'd4
    } dma_mode_e;

    // cpu register map
    typedef enum logic [1:0] {
        reg_ctrl     = 2'd0,
        reg_count    = 2'd1,
        reg_data     = 2'd2,
        reg_pio_stat = 2'd3
    } reg_addr_e;

    // scsi handshake sequencer
    typedef enum logic [2:0] {
        st_idle,
        st_wait_req,
        st_ack,
        st_wait_release,
        st_flush
    } seq_state_e;

endpackage

// ==== dma_ctrl_regs.sv ====
`timescale 1ns/1ps

module dma_ctrl_regs (
    input  logic                             clk,
    input  logic                             rst_n,
    input  logic                             cpu_wr,
    input  logic                             cpu_rd,
    input  scsi_dma_pkg::reg_addr_e          cpu_addr,
    input  logic [scsi_dma_pkg::WORD_W-1:0]  cpu_wdata,
    output logic [scsi_dma_pkg::WORD_W-1:0]  cpu_rdata,
    output scsi_dma_pkg::dma_mode_e          mode,
    output logic [scsi_dma_pkg::COUNT_W-1:0] count,
    output logic                             start,
    output logic                             pio_go,
    output logic [scsi_dma_pkg::BYTE_W-1:0]  pio_tx_byte,
    output logic                             cpu_push,
    output logic [scsi_dma_pkg::WORD_W-1:0]  cpu_push_data,
    output logic                             cpu_pop,
    output logic                             rx_clear,
    input  logic                             done,
    input  logic [scsi_dma_pkg::WORD_W-1:0]  fifo_head,
    input  logic                             fifo_empty,
    input  logic                             fifo_full,
    input  logic [scsi_dma_pkg::BYTE_W-1:0]  pio_rx_byte,
    input  logic                             pio_rx_valid
);
    import scsi_dma_pkg::*;

    logic              wr_ctrl;
    logic              wr_count;
    logic              wr_data;
    logic              wr_pio;
    logic [WORD_W-1:0] status_word;

    // address decode of write strobes
    assign wr_ctrl  = cpu_wr && (cpu_addr == reg_ctrl);
    assign wr_count = cpu_wr && (cpu_addr == reg_count);
    assign wr_data  = cpu_wr && (cpu_addr == reg_data);
    assign wr_pio   = cpu_wr && (cpu_addr == reg_pio_stat);

    // data window onto the fifo, writes to a full fifo are dropped
    assign cpu_push      = wr_data && !fifo_full;
    assign cpu_push_data = cpu_wdata;
    // reads of an empty fifo return the stale head and do not pop
    assign cpu_pop       = cpu_rd && (cpu_addr == reg_data) && !fifo_empty;
    // status read consumes the pio receive flag
    assign rx_clear      = cpu_rd && (cpu_addr == reg_pio_stat);

    // done, empty, full, pio valid in the low nibble, pio byte in 15:8
    assign status_word = {{(WORD_W - 16){1'b0}}, pio_rx_byte, 4'b0000,
                          pio_rx_valid, fifo_full, fifo_empty, done};

    // mode and count, start and pio_go delayed one cycle so the
    // sequencer sees them together with the new mode
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            mode   <= mode_idle;
            count  <= '0;
            start  <= 1'b0;
            pio_go <= 1'b0;
        end else begin
            start  <= wr_ctrl;
            pio_go <= wr_pio;
            if (wr_ctrl) begin
                mode <= dma_mode_e'(cpu_wdata[$bits(dma_mode_e)-1:0]);
            end
            if (wr_count) begin
                count <= cpu_wdata[COUNT_W-1:0];
            end
        end
    end

    // byte for the next pio out transfer
    always_ff @(posedge clk) begin
        if (wr_pio) begin
            pio_tx_byte <= cpu_wdata[BYTE_W-1:0];
        end
    end

    // registered read mux, data shows up the cycle after cpu_rd
    always_ff @(posedge clk) begin
        if (cpu_rd) begin
            case (cpu_addr)
                reg_ctrl:  cpu_rdata <= {{(WORD_W - $bits(dma_mode_e)){1'b0}}, mode};
                reg_count: cpu_rdata <= {{(WORD_W - COUNT_W){1'b0}}, count};
                reg_data:  cpu_rdata <= fifo_head;
                default:   cpu_rdata <= status_word;
            endcase
        end
    end

    // host strobes are exclusive
    a_no_wr_rd: assert property (@(posedge clk) disable iff (!rst_n)
        !(cpu_wr && cpu_rd))
        else $error("cpu_wr and cpu_rd asserted together");

endmodule

// ==== dma_fifo.sv ====
`timescale 1ns/1ps

module dma_fifo #(
    parameter int FIFO_DEPTH = 8
) (
    input  logic                            clk,
    input  logic                            rst_n,
    input  logic                            cpu_push,
    input  logic [scsi_dma_pkg::WORD_W-1:0] cpu_push_data,
    input  logic                            scsi_push,
    input  logic [scsi_dma_pkg::WORD_W-1:0] scsi_push_data,
    input  logic                            cpu_pop,
    input  logic                            scsi_pop,
    output logic [scsi_dma_pkg::WORD_W-1:0] head,
    output logic                            empty,
    output logic                            full
);
    import scsi_dma_pkg::*;

    // depth is a power of two, pointers wrap on their own
    localparam int PTR_W = $clog2(FIFO_DEPTH);

    logic [WORD_W-1:0] mem [FIFO_DEPTH];
    logic [PTR_W-1:0]  wr_ptr;
    logic [PTR_W-1:0]  rd_ptr;
    logic [PTR_W:0]    fill;
    logic              push;
    logic              pop;
    logic [WORD_W-1:0] push_data;

    // only one side pushes in a given mode
    assign push      = cpu_push || scsi_push;
    assign pop       = cpu_pop || scsi_pop;
    assign push_data = scsi_push ? scsi_push_data : cpu_push_data;

    // storage
    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= push_data;
        end
    end

    // pointers and occupancy
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            fill   <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10:   fill <= fill + 1'b1;
                2'b01:   fill <= fill - 1'b1;
                default: fill <= fill;
            endcase
        end
    end

    // first word falls through to the head
    assign head  = mem[rd_ptr];
    assign empty = (fill == '0);
    assign full  = (fill == (PTR_W + 1)'(FIFO_DEPTH));

    a_one_pusher: assert property (@(posedge clk) disable iff (!rst_n)
        !(cpu_push && scsi_push))
        else $error("cpu and scsi side push in the same cycle");
    a_no_overflow: assert property (@(posedge clk) disable iff (!rst_n)
        push |-> !full)
        else $error("push into full fifo");
    a_no_underflow: assert property (@(posedge clk) disable iff (!rst_n)
        pop |-> !empty)
        else $error("pop from empty fifo");

endmodule

// ==== scsi_datapath.sv ====
`timescale 1ns/1ps

module scsi_datapath (
    input  logic                            clk,
    input  logic                            rst_n,
    input  logic [1:0]                      lane_sel,
    input  logic                            tx_from_pio,
    input  logic [scsi_dma_pkg::WORD_W-1:0] fifo_head,
    input  logic [scsi_dma_pkg::BYTE_W-1:0] pio_tx_byte,
    input  logic [scsi_dma_pkg::BYTE_W-1:0] scsi_din,
    input  logic                            rx_take,
    input  logic                            pack_clear,
    input  logic                            rx_clear,
    input  scsi_dma_pkg::dma_mode_e         mode,
    output logic [scsi_dma_pkg::BYTE_W-1:0] scsi_dout,
    output logic [scsi_dma_pkg::WORD_W-1:0] packed_word,
    output logic [scsi_dma_pkg::BYTE_W-1:0] pio_rx_byte,
    output logic                            pio_rx_valid
);
    import scsi_dma_pkg::*;

    logic [LANES-1:0]  lane_dec;
    logic [BYTE_W-1:0] lane_byte;
    logic [WORD_W-1:0] pack_q;
    logic              take_pio;
    logic              take_dma;

    // one-hot lane select, lane 3 is bits 31:24 and goes out first
    always_comb begin
        lane_dec           = '0;
        lane_dec[lane_sel] = 1'b1;
    end

    // and-or byte mux over the head word
    always_comb begin
        lane_byte = '0;
        for (int i = 0; i < LANES; i++) begin
            lane_byte = lane_byte | (fifo_head[i*BYTE_W +: BYTE_W] & {BYTE_W{lane_dec[i]}});
        end
    end

    // pio byte overrides the fifo lane
    assign scsi_dout = tx_from_pio ? pio_tx_byte : lane_byte;

    // received byte goes either to the cpu latch or into the pack word
    assign take_pio = rx_take && (mode == mode_pio_in);
    assign take_dma = rx_take && (mode == mode_dma_in);

    // valid flag, a new byte wins over a clearing status read
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pio_rx_valid <= 1'b0;
        end else if (take_pio) begin
            pio_rx_valid <= 1'b1;
        end else if (rx_clear) begin
            pio_rx_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (take_pio) begin
            pio_rx_byte <= scsi_din;
        end
    end

    // pack register, cleared lanes stay zero for a partial flush
    always_ff @(posedge clk) begin
        if (pack_clear) begin
            pack_q <= '0;
        end
        if (take_dma) begin
            pack_q[lane_sel*BYTE_W +: BYTE_W] <= scsi_din;
        end
    end

    assign packed_word = pack_q;

endmodule

// ==== scsi_dma_seq.sv ====
`timescale 1ns/1ps

module scsi_dma_seq (
    input  logic                             clk,
    input  logic                             rst_n,
    input  scsi_dma_pkg::dma_mode_e          mode,
    input  logic [scsi_dma_pkg::COUNT_W-1:0] count,
    input  logic                             start,
    input  logic                             pio_go,
    input  logic                             scsi_req,
    input  logic                             fifo_empty,
    input  logic                             fifo_full,
    output logic                             scsi_ack,
    output logic                             scsi_dout_en,
    output logic [1:0]                       lane_sel,
    output logic                             tx_from_pio,
    output logic                             rx_take,
    output logic                             pack_clear,
    output logic                             scsi_push,
    output logic                             scsi_pop,
    output logic                             done
);
    import scsi_dma_pkg::*;

    seq_state_e         state;
    logic [COUNT_W-1:0] bytes_left;
    logic [1:0]         lane;
    logic               req_q;
    logic               push_q;
    logic               done_q;
    logic               is_out;
    logic               is_in;
    logic               can_serve;
    logic               last_byte;
    logic               need_flush;

    assign is_out = (mode == mode_dma_out) || (mode == mode_pio_out);
    assign is_in  = (mode == mode_dma_in) || (mode == mode_pio_in);

    // out waits for a head word and in waits for room in the fifo
    always_comb begin
        case (mode)
            mode_dma_out: can_serve = !fifo_empty;
            mode_dma_in:  can_serve = !fifo_full;
            mode_pio_out: can_serve = 1'b1;
            mode_pio_in:  can_serve = 1'b1;
            default:      can_serve = 1'b0;
        endcase
    end

    assign last_byte  = (bytes_left == COUNT_W'(1));
    // count ran out before lane 0 was filled
    assign need_flush = (mode == mode_dma_in) && (lane != 2'd0);

    // ack is one state wide and the data and sample strobes ride on it
    assign scsi_ack     = (state == st_ack);
    assign scsi_dout_en = scsi_ack && is_out;
    assign rx_take      = scsi_ack && is_in;
    assign tx_from_pio  = (mode == mode_pio_out);
    assign lane_sel     = lane;
    // head word leaves after its last lane or the last byte
    assign scsi_pop     = scsi_ack && (mode == mode_dma_out) && ((lane == 2'd0) || last_byte);
    assign scsi_push    = push_q || (state == st_flush);
    // zero the pack word when it is pushed and when a transfer starts
    assign pack_clear   = scsi_push || start;
    assign done         = done_q;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state      <= st_idle;
            bytes_left <= '0;
            lane       <= 2'd3;
            req_q      <= 1'b0;
            push_q     <= 1'b0;
            done_q     <= 1'b0;
        end else begin
            req_q  <= scsi_req;
            push_q <= 1'b0;
            // a new transfer clears done and a later set below wins
            if (start || pio_go) begin
                done_q <= 1'b0;
            end
            case (state)
                st_idle: begin
                    lane <= 2'd3;
                    if (start && ((mode == mode_dma_out) || (mode == mode_dma_in))) begin
                        if (count == '0) begin
                            done_q <= 1'b1;
                        end else begin
                            bytes_left <= count;
                            state      <= st_wait_req;
                        end
                    end else if ((start && (mode == mode_pio_in)) ||
                                 (pio_go && (mode == mode_pio_out))) begin
                        // pio moves a single byte
                        bytes_left <= COUNT_W'(1);
                        state      <= st_wait_req;
                    end
                end
                st_wait_req: begin
                    // request is registered so ack comes two cycles after req
                    if (req_q && can_serve) begin
                        state <= st_ack;
                    end
                end
                st_ack: begin
                    bytes_left <= bytes_left - 1'b1;
                    lane       <= lane - 1'b1;
                    // full word packed and pushed next cycle
                    if ((mode == mode_dma_in) && (lane == 2'd0)) begin
                        push_q <= 1'b1;
                    end
                    if (last_byte && need_flush) begin
                        state <= st_flush;
                    end else begin
                        if (last_byte) begin
                            done_q <= 1'b1;
                        end
                        state <= st_wait_release;
                    end
                end
                st_flush: begin
                    done_q <= 1'b1;
                    state  <= st_wait_release;
                end
                st_wait_release: begin
                    // target must drop req before the next byte
                    if (!req_q) begin
                        state <= (bytes_left == '0) ? st_idle : st_wait_req;
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

    a_ack_pulse: assert property (@(posedge clk) disable iff (!rst_n)
        scsi_ack |=> !scsi_ack)
        else $error("scsi_ack held longer than one cycle");

endmodule

// ==== scsi_dma_top.sv ====
`timescale 1ns/1ps

module scsi_dma_top #(
    parameter int FIFO_DEPTH = 8
) (
    input  logic                            clk,
    input  logic                            rst_n,
    input  logic                            cpu_wr,
    input  logic                            cpu_rd,
    input  scsi_dma_pkg::reg_addr_e         cpu_addr,
    input  logic [scsi_dma_pkg::WORD_W-1:0] cpu_wdata,
    output logic [scsi_dma_pkg::WORD_W-1:0] cpu_rdata,
    input  logic                            scsi_req,
    input  logic [scsi_dma_pkg::BYTE_W-1:0] scsi_din,
    output logic [scsi_dma_pkg::BYTE_W-1:0] scsi_dout,
    output logic                            scsi_dout_en,
    output logic                            scsi_ack,
    output logic                            irq
);
    import scsi_dma_pkg::*;

    // register block controls
    dma_mode_e          mode;
    logic [COUNT_W-1:0] count;
    logic               start;
    logic               pio_go;
    logic               done;
    logic               rx_clear;
    // fifo traffic
    logic               cpu_push;
    logic               cpu_pop;
    logic               scsi_push;
    logic               scsi_pop;
    logic [WORD_W-1:0]  cpu_push_data;
    logic [WORD_W-1:0]  fifo_head;
    logic [WORD_W-1:0]  packed_word;
    logic               fifo_empty;
    logic               fifo_full;
    // pio bytes
    logic [BYTE_W-1:0]  pio_tx_byte;
    logic [BYTE_W-1:0]  pio_rx_byte;
    logic               pio_rx_valid;
    // datapath steering
    logic [1:0]         lane_sel;
    logic               tx_from_pio;
    logic               rx_take;
    logic               pack_clear;

    // interrupt is the done level
    assign irq = done;

    dma_ctrl_regs u_regs (.*);

    dma_fifo #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) u_fifo (
        .clk            (clk),
        .rst_n          (rst_n),
        .cpu_push       (cpu_push),
        .cpu_push_data  (cpu_push_data),
        .scsi_push      (scsi_push),
        .scsi_push_data (packed_word),
        .cpu_pop        (cpu_pop),
        .scsi_pop       (scsi_pop),
        .head           (fifo_head),
        .empty          (fifo_empty),
        .full           (fifo_full)
    );

    scsi_datapath u_datapath (.*);

    scsi_dma_seq u_seq (.*);

endmodule

// ==== tb_scsi_dma.sv ====
`timescale 1ns/1ps

module tb_scsi_dma;
    import scsi_dma_pkg::*;

    // cycles allowed for any single handshake or completion
    localparam int ACK_TIMEOUT  = 200;
    localparam int DONE_TIMEOUT = 200;

    logic              clk;
    logic              rst_n;
    logic              cpu_wr;
    logic              cpu_rd;
    reg_addr_e         cpu_addr;
    logic [WORD_W-1:0] cpu_wdata;
    logic [WORD_W-1:0] cpu_rdata;
    logic              scsi_req;
    logic [BYTE_W-1:0] scsi_din;
    logic [BYTE_W-1:0] scsi_dout;
    logic              scsi_dout_en;
    logic              scsi_ack;
    logic              irq;
    integer            seed;

    scsi_dma_top #(
        .FIFO_DEPTH (8)
    ) dut (.*);

    // 40 ns period
    always #20 clk = ~clk;

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("FAIL: see errors above");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_word(input string name, input logic [WORD_W-1:0] exp,
                              input logic [WORD_W-1:0] act);
        if (act !== exp) begin
            abort_run($sformatf("mismatch %s: expected %h, actual %h", name, exp, act));
        end
    endtask

    task automatic check_byte(input string name, input logic [BYTE_W-1:0] exp,
                              input logic [BYTE_W-1:0] act);
        if (act !== exp) begin
            abort_run($sformatf("mismatch %s: expected %h, actual %h", name, exp, act));
        end
    endtask

    task automatic check_mode(input string name, input dma_mode_e exp, input dma_mode_e act);
        if (act !== exp) begin
            abort_run($sformatf("mismatch %s: expected %s, actual %s",
                                name, exp.name(), act.name()));
        end
    endtask

    // one-cycle write strobe
    task automatic cpu_write(input reg_addr_e addr, input logic [WORD_W-1:0] data);
        @(posedge clk);
        cpu_wr    <= 1'b1;
        cpu_addr  <= addr;
        cpu_wdata <= data;
        @(posedge clk);
        cpu_wr    <= 1'b0;
    endtask

    // read data is registered, sampled mid-cycle after the strobe edge
    task automatic cpu_read(input reg_addr_e addr, output logic [WORD_W-1:0] data);
        @(posedge clk);
        cpu_rd   <= 1'b1;
        cpu_addr <= addr;
        @(posedge clk);
        cpu_rd   <= 1'b0;
        @(negedge clk);
        data = cpu_rdata;
    endtask

    task automatic wait_for_ack(input string what);
        int cycles;
        cycles = 0;
        @(negedge clk);
        while (!scsi_ack) begin
            cycles++;
            if (cycles > ACK_TIMEOUT) begin
                abort_run($sformatf("timeout waiting for scsi_ack in %s", what));
            end
            @(negedge clk);
        end
    endtask

    task automatic wait_done(input string what);
        int cycles;
        cycles = 0;
        @(negedge clk);
        while (!irq) begin
            cycles++;
            if (cycles > DONE_TIMEOUT) begin
                abort_run($sformatf("timeout waiting for done/irq in %s", what));
            end
            @(negedge clk);
        end
    endtask

    // target side of an out byte, data is read during the ack pulse
    task automatic target_take_byte(input string what, output logic [BYTE_W-1:0] data,
                                    output logic en);
        @(posedge clk);
        scsi_req <= 1'b1;
        wait_for_ack(what);
        data = scsi_dout;
        en   = scsi_dout_en;
        @(posedge clk);
        scsi_req <= 1'b0;
    endtask

    task automatic target_send_byte(input string what, input logic [BYTE_W-1:0] data);
        @(posedge clk);
        scsi_req <= 1'b1;
        scsi_din <= data;
        wait_for_ack(what);
        @(posedge clk);
        scsi_req <= 1'b0;
    endtask

    task automatic take_and_check(input string name, input logic [BYTE_W-1:0] exp);
        logic [BYTE_W-1:0] got;
        logic              en;
        target_take_byte(name, got, en);
        if (en !== 1'b1) begin
            abort_run($sformatf("scsi_dout_en was not high at the ack in %s", name));
        end
        check_byte(name, exp, got);
    endtask

    task automatic test_reset_and_modes();
        logic [WORD_W-1:0] rd;
        dma_mode_e         modes [4];
        modes[0] = mode_idle;
        modes[1] = mode_dma_out;
        modes[2] = mode_dma_in;
        modes[3] = mode_pio_out;
        // pio byte is not reset, only the flag nibble is known
        cpu_read(reg_pio_stat, rd);
        check_word("reset status", 32'h0000_0002, rd & 32'h0000_000F);
        // count is zero here, so dma starts finish at once
        for (int i = 0; i < 4; i++) begin
            cpu_write(reg_ctrl, {29'd0, modes[i]});
            cpu_read(reg_ctrl, rd);
            check_mode("mode readback", modes[i], dma_mode_e'(rd[2:0]));
        end
    endtask

    task automatic test_dma_out();
        logic [WORD_W-1:0] words [3];
        logic [WORD_W-1:0] rd;
        int                lane;
        for (int i = 0; i < 3; i++) begin
            words[i] = $random(seed);
            cpu_write(reg_data, words[i]);
        end
        cpu_write(reg_count, 32'd12);
        cpu_write(reg_ctrl, {29'd0, mode_dma_out});
        // big-endian, lane 3 leaves first
        for (int i = 0; i < 12; i++) begin
            lane = 3 - (i % 4);
            take_and_check("dma out byte", words[i / 4][lane*8 +: 8]);
        end
        wait_done("dma out");
        cpu_read(reg_pio_stat, rd);
        check_word("dma out status", 32'h0000_0003, rd & 32'h0000_0007);
    endtask

    task automatic test_dma_in_partial();
        logic [BYTE_W-1:0] bytes [6];
        logic [WORD_W-1:0] rd;
        cpu_write(reg_count, 32'd6);
        cpu_write(reg_ctrl, {29'd0, mode_dma_in});
        for (int i = 0; i < 6; i++) begin
            bytes[i] = 8'($random(seed));
            target_send_byte("dma in byte", bytes[i]);
        end
        wait_done("dma in");
        cpu_read(reg_data, rd);
        check_word("dma in full word", {bytes[0], bytes[1], bytes[2], bytes[3]}, rd);
        // partial word keeps its unfilled low lanes at zero
        cpu_read(reg_data, rd);
        check_word("dma in partial word", {bytes[4], bytes[5], 16'h0000}, rd);
    endtask

    task automatic test_back_pressure();
        logic [WORD_W-1:0] word;
        cpu_write(reg_count, 32'd4);
        cpu_write(reg_ctrl, {29'd0, mode_dma_out});
        @(posedge clk);
        scsi_req <= 1'b1;
        repeat (20) begin
            @(negedge clk);
            if (scsi_ack) begin
                abort_run("scsi_ack came while the fifo was empty in back pressure");
            end
        end
        word = $random(seed);
        cpu_write(reg_data, word);
        for (int i = 0; i < 4; i++) begin
            take_and_check("back pressure byte", word[(3 - i)*8 +: 8]);
        end
        wait_done("back pressure");
    endtask

    task automatic test_pio();
        logic [WORD_W-1:0] rd;
        logic [BYTE_W-1:0] tx;
        logic [BYTE_W-1:0] rx;
        tx = 8'($random(seed));
        rx = 8'($random(seed));
        cpu_write(reg_ctrl, {29'd0, mode_pio_out});
        cpu_read(reg_ctrl, rd);
        check_mode("pio out mode", mode_pio_out, dma_mode_e'(rd[2:0]));
        cpu_write(reg_pio_stat, {24'd0, tx});
        take_and_check("pio out byte", tx);
        wait_done("pio out");
        // writing pio in starts a single byte receive
        cpu_write(reg_ctrl, {29'd0, mode_pio_in});
        cpu_read(reg_ctrl, rd);
        check_mode("pio in mode", mode_pio_in, dma_mode_e'(rd[2:0]));
        target_send_byte("pio in byte", rx);
        wait_done("pio in");
        cpu_read(reg_pio_stat, rd);
        check_word("pio in status", {16'h0000, rx, 8'h0B}, rd);
        // first status read cleared the valid flag
        cpu_read(reg_pio_stat, rd);
        check_word("pio in status reread", {16'h0000, rx, 8'h03}, rd);
    endtask

    initial begin
        seed      = 74;
        clk       = 1'b0;
        rst_n     = 1'b0;
        cpu_wr    = 1'b0;
        cpu_rd    = 1'b0;
        cpu_addr  = reg_ctrl;
        cpu_wdata = '0;
        scsi_req  = 1'b0;
        scsi_din  = '0;
        repeat (10) @(posedge clk);
        rst_n <= 1'b1;
        @(posedge clk);
        test_reset_and_modes();
        test_dma_out();
        test_dma_in_partial();
        test_back_pressure();
        test_pio();
        $display("PASS: all tests");
        $finish;
    end

endmodule

// ==== sources.f ====
scsi_dma_pkg.sv
dma_ctrl_regs.sv
dma_fifo.sv
scsi_datapath.sv
scsi_dma_seq.sv
scsi_dma_top.sv
tb_scsi_dma.sv

// ==== Makefile ====
SRCS := $(wildcard *.sv)

obj_dir/Vtb_scsi_dma: sources.f $(SRCS)
	verilator --binary --timing --assert -Wno-fatal -f sources.f \
		--top-module tb_scsi_dma -o Vtb_scsi_dma

run: obj_dir/Vtb_scsi_dma
	@out="$$(./obj_dir/Vtb_scsi_dma)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "PASS: all tests"

clean:
	rm -rf obj_dir

.PHONY: run clean
